/* run.sh */
#!/bin/sh
verilator --binary -j 0 --timescale 1ns/100ps --top-module memCtrlTb -f verilog.f -o memCtrlSim || exit 1
out="$(./obj_dir/memCtrlSim 2>&1)"
echo "$out"
echo "$out" | grep -qx "sim passed" && echo "PASS" || { echo "FAIL"; exit 1; }

/* verif/memCtrlTb.sv */
`timescale 1ns/100ps

module memCtrlTb;
    import memBusPkg::*;

    typedef enum logic [1:0] {
        opFetch,
        opLoad,
        opStore,
        opBoth
    } op_t;

    typedef struct packed {
        op_t        op;
        addr_t      addr;
        accessLen_t len;
        word_t      storeWord;
        word_t      expWord;
    } entry_t;

    localparam int FETCH_BYTES = 4;
    localparam int NUM_ENTRIES = 14;
    localparam int NUM_PASSES = 2;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * NUM_PASSES * 12 + 200;
    // fetch side of a combined entry reads 16 bytes above the data access
    localparam addr_t FETCH_OFS = 32'h10;

    logic clk;
    logic rst;
    logic rdy = 1'b1;
    logic fetchEn;
    logic dcEn;
    logic dcStore;
    addr_t fetchAddr;
    addr_t dcAddr;
    addr_t memAddr;
    accessLen_t dcLen;
    word_t dcData;
    word_t fetchInst;
    word_t dcResult;
    logic fetchDone;
    logic dcDone;
    logic memWrite;
    memByte_t memWData;
    memByte_t memRData;
    int writeCount;

    entry_t stimTable [NUM_ENTRIES];
    memByte_t shadow [256];
    logic [15:0] lfsr = 16'd5;
    logic stallOn = 1'b0;
    int cycleCount = 0;
    int fetchDoneCount = 0;
    int dcDoneCount = 0;
    int fetchRequests = 0;
    int dcRequests = 0;

    memCtrlTop #(
        .FETCH_BYTES (FETCH_BYTES)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (rdy),
        .i_fetchEn   (fetchEn),
        .i_fetchAddr (fetchAddr),
        .o_fetchDone (fetchDone),
        .o_fetchInst (fetchInst),
        .i_dcEn      (dcEn),
        .i_dcStore   (dcStore),
        .i_dcLen     (dcLen),
        .i_dcAddr    (dcAddr),
        .i_dcData    (dcData),
        .o_dcDone    (dcDone),
        .o_dcData    (dcResult),
        .i_memData   (memRData),
        .o_memAddr   (memAddr),
        .o_memWrite  (memWrite),
        .o_memData   (memWData)
    );

    ramModel ram (
        .clk          (clk),
        .i_en         (rdy),
        .i_addr       (memAddr),
        .i_write      (memWrite),
        .i_wdata      (memWData),
        .o_rdata      (memRData),
        .o_writeCount (writeCount)
    );

    function automatic logic [15:0] nextLfsr(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // little endian word from the shadow copy
    function automatic word_t shadowWord(input addr_t base, input int n);
        word_t w;
        addr_t a;
        w = '0;
        for (int k = 0; k < n; k++) begin
            a = base + addr_t'(k);
            w = w | (word_t'(shadow[a[7:0]]) << (8 * k));
        end
        return w;
    endfunction

    task automatic failNow();
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            failNow();
        end
    endtask

    task automatic checkByte(input string name, input memByte_t got, input memByte_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
            failNow();
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            failNow();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // pause when two fresh lfsr bits are both set
    always @(posedge clk) begin
        bit b0;
        bit b1;
        b0 = lfsr[0];
        lfsr = nextLfsr(lfsr);
        b1 = lfsr[0];
        lfsr = nextLfsr(lfsr);
        rdy <= !(stallOn && b0 && b1);
    end

    always @(negedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("timeout, the table did not finish within %0d cycles", TIMEOUT_CYCLES);
            failNow();
        end
        if (rst && (fetchDone || dcDone || memWrite)) begin
            $display("done pulse or write strobe seen during reset");
            failNow();
        end
        if (memWrite && !rdy) begin
            $display("write strobe high while rdy is low");
            failNow();
        end
        fetchDoneCount += int'(fetchDone);
        dcDoneCount += int'(dcDone);
    end

    task automatic applyEntry(input entry_t e, input bit timed);
        bit wantFetch;
        bit wantData;
        bit gotFetch;
        bit gotData;
        int cycles;
        int writesBefore;
        int n;
        addr_t fAddr;
        addr_t a;
        word_t fetchWord;
        word_t dataWord;
        wantFetch = (e.op == opFetch) || (e.op == opBoth);
        wantData = (e.op != opFetch);
        gotFetch = 1'b0;
        gotData = 1'b0;
        cycles = 0;
        n = (e.op == opFetch) ? FETCH_BYTES : int'(e.len);
        fAddr = (e.op == opBoth) ? e.addr + FETCH_OFS : e.addr;
        writesBefore = writeCount;
        fetchRequests += int'(wantFetch);
        dcRequests += int'(wantData);
        @(posedge clk);
        fetchEn <= wantFetch;
        fetchAddr <= fAddr;
        dcEn <= wantData;
        dcStore <= (e.op == opStore);
        dcLen <= e.len;
        dcAddr <= e.addr;
        dcData <= e.storeWord;
        while ((wantFetch && !gotFetch) || (wantData && !gotData)) begin
            @(negedge clk);
            cycles++;
            if ((fetchDone && (!wantFetch || gotFetch)) || (dcDone && (!wantData || gotData))) begin
                $display("extra done pulse on a port with no pending request");
                failNow();
            end
            if (fetchDone && wantData && !gotData) begin
                $display("fetch done arrived before the data done");
                failNow();
            end
            if (fetchDone) begin
                gotFetch = 1'b1;
                fetchWord = fetchInst;
            end
            if (dcDone) begin
                gotData = 1'b1;
                dataWord = dcResult;
            end
            if (fetchDone || dcDone) begin
                // enable drops on the edge that ends the done cycle
                @(posedge clk);
                fetchEn <= fetchEn && !gotFetch;
                dcEn <= dcEn && !gotData;
            end
        end
        @(negedge clk);
        if (timed && e.op != opBoth) begin
            checkCount("latency", cycles, n + ((e.op == opStore) ? 2 : 3));
        end
        if (wantFetch) begin
            checkWord("o_fetchInst", fetchWord, shadowWord(fAddr, FETCH_BYTES));
        end
        if (e.op == opStore) begin
            for (int k = 0; k < int'(e.len); k++) begin
                a = e.addr + addr_t'(k);
                shadow[a[7:0]] = memByte_t'(e.storeWord >> (8 * k));
            end
            checkCount("ram write count", writeCount - writesBefore, int'(e.len));
            for (int k = 0; k < 4; k++) begin
                a = e.addr + addr_t'(k);
                checkByte("ram byte", ram.mem[a[7:0]], shadow[a[7:0]]);
            end
        end else if (wantData) begin
            checkWord("o_dcData", dataWord, e.expWord);
        end
    endtask

    initial begin
        rst = 1'b1;
        // a store and a fetch asked for during reset must be ignored
        fetchEn = 1'b1;
        fetchAddr = '0;
        dcEn = 1'b1;
        dcStore = 1'b1;
        dcLen = 3'd4;
        dcAddr = 32'h40;
        dcData = 32'hFFFFFFFF;
        for (int a = 0; a < 256; a++) begin
            shadow[a[7:0]] = memByte_t'(a) ^ 8'h5A;
        end
        // op, addr, len, store word, expected word
        stimTable[0]  = '{opFetch, 32'h10, 3'd4, 32'h0, 32'h49484B4A};
        stimTable[1]  = '{opLoad,  32'h21, 3'd1, 32'h0, 32'h0000007B};
        stimTable[2]  = '{opLoad,  32'h32, 3'd2, 32'h0, 32'h00006968};
        stimTable[3]  = '{opLoad,  32'h44, 3'd4, 32'h0, 32'h1D1C1F1E};
        stimTable[4]  = '{opStore, 32'h80, 3'd1, 32'hDEADBEEF, 32'h0};
        stimTable[5]  = '{opLoad,  32'h80, 3'd4, 32'h0, 32'hD9D8DBEF};
        stimTable[6]  = '{opStore, 32'h90, 3'd2, 32'h12345678, 32'h0};
        stimTable[7]  = '{opLoad,  32'h8F, 3'd4, 32'h0, 32'hC85678D5};
        stimTable[8]  = '{opStore, 32'hA0, 3'd4, 32'hCAFEF00D, 32'h0};
        stimTable[9]  = '{opLoad,  32'hA2, 3'd4, 32'h0, 32'hFFFECAFE};
        stimTable[10] = '{opLoad,  32'h9E, 3'd4, 32'h0, 32'hF00DC5C4};
        stimTable[11] = '{opBoth,  32'h50, 3'd2, 32'h0, 32'h00000B0A};
        stimTable[12] = '{opFetch, 32'hFC, 3'd4, 32'h0, 32'hA5A4A7A6};
        stimTable[13] = '{opLoad,  32'h80, 3'd1, 32'h0, 32'h000000EF};
        repeat (8) @(posedge clk);
        fetchEn <= 1'b0;
        dcEn <= 1'b0;
        dcStore <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // the first pass checks latency and the second runs with random pauses
        for (int pass = 0; pass < NUM_PASSES; pass++) begin
            stallOn <= (pass != 0);
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                applyEntry(stimTable[i], pass == 0);
            end
        end
        checkCount("fetch done pulses", fetchDoneCount, fetchRequests);
        checkCount("data done pulses", dcDoneCount, dcRequests);
        $display("sim passed");
        $finish;
    end

endmodule

/* verif/ramModel.sv */
`timescale 1ns/100ps

module ramModel (
    input  logic                 clk,
    input  logic                 i_en,
    input  memBusPkg::addr_t     i_addr,
    input  logic                 i_write,
    input  memBusPkg::memByte_t  i_wdata,
    output memBusPkg::memByte_t  o_rdata,
    output int                   o_writeCount
);
    import memBusPkg::*;

    localparam int DEPTH = 256;

    memByte_t mem [DEPTH];

    // every byte is its full index xor 0x5a
    initial begin
        for (int a = 0; a < DEPTH; a++) begin
            mem[a[7:0]] = memByte_t'(a) ^ 8'h5A;
        end
        o_rdata = '0;
        o_writeCount = 0;
    end

    // read data lags the address by one cycle, frozen during a pause
    always @(posedge clk) begin
        if (i_en) begin
            o_rdata <= mem[i_addr[7:0]];
        end
        if (i_write) begin
            mem[i_addr[7:0]] <= i_wdata;
            o_writeCount <= o_writeCount + 1;
        end
    end

endmodule

/* verilog.f */
verilog/memBusPkg.sv
verilog/memCtrlPkg.sv
verilog/memArbiter.sv
verilog/byteEngine.sv
verilog/memCtrlTop.sv
verif/ramModel.sv
verif/memCtrlTb.sv

/* verilog/byteEngine.sv */
`timescale 1ns/100ps

module byteEngine (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_rdy,

    input  logic                     i_start,
    input  memCtrlPkg::accessKind_t  i_kind,
    input  memBusPkg::addr_t         i_addr,
    input  memBusPkg::accessLen_t    i_len,
    input  memBusPkg::word_t         i_storeData,

    input  memBusPkg::memByte_t      i_memData,
    output memBusPkg::addr_t         o_memAddr,
    output logic                     o_memWrite,
    output memBusPkg::memByte_t      o_memData,

    output logic                     o_done,
    output memBusPkg::word_t         o_result
);
    import memBusPkg::*;
    import memCtrlPkg::*;

    byteStage_t stage;
    byteStage_t stageM1;
    byteStage_t stageM2;
    byteStage_t lenStage;
    byteStage_t lenM1;
    byteStage_t lastStage;

    logic [1:0] outLane;
    logic [1:0] capLane;
    logic [1:0] lastLane;

    logic  active;
    logic  isWrite;
    logic  inAddrPhase;
    logic  capture;
    logic  doneNow;

    word_t assembled;
    word_t liveByte;

    assign isWrite  = (i_kind == kindWrite);
    assign lenStage = byteStage_t'(i_len);
    assign lenM1    = lenStage - byteStage_t'(1);
    assign stageM1  = stage - byteStage_t'(1);
    assign stageM2  = stage - byteStage_t'(2);

    assign outLane  = stageM1[1:0];
    assign capLane  = stageM2[1:0];
    assign lastLane = lenM1[1:0];

    // a read ends one stage late, the last byte is still on the bus
    assign lastStage   = isWrite ? lenStage : lenStage + byteStage_t'(1);
    assign active      = (stage != '0);
    assign inAddrPhase = active && (stage <= lenStage);
    assign doneNow     = i_rdy && active && (stage == lastStage);

    // byte from stage s-1 address shows up in stage s
    assign capture = !isWrite && (stage >= byteStage_t'(2)) && (stage <= lenStage);

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else if (i_rdy) begin
            if (!active) begin
                if (i_start) begin
                    stage <= byteStage_t'(1);
                end
            end else if (doneNow) begin
                stage <= '0;
            end else begin
                stage <= stage + byteStage_t'(1);
            end
        end
    end

    // lanes above the length stay zero from the clear at start
    always_ff @(posedge clk) begin
        if (i_rdy) begin
            if (!active && i_start) begin
                assembled <= '0;
            end else if (capture) begin
                assembled[{capLane, 3'b000} +: 8] <= i_memData;
            end
        end
    end

    // address holds during a pause, the strobe does not
    assign o_memAddr  = i_addr + (active ? addr_t'(stageM1) : addr_t'(0));
    assign o_memWrite = i_rdy && isWrite && inAddrPhase;
    assign o_memData  = i_storeData[{outLane, 3'b000} +: 8];

    assign liveByte = word_t'(i_memData) << {lastLane, 3'b000};
    assign o_result = isWrite ? '0 : (assembled | liveByte);
    assign o_done   = doneNow;

endmodule

/* verilog/memArbiter.sv */
`timescale 1ns/100ps

module memArbiter #(
    parameter int FETCH_BYTES = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_rdy,

    input  logic                     i_fetchEn,
    input  memBusPkg::addr_t         i_fetchAddr,

    input  logic                     i_dcEn,
    input  logic                     i_dcStore,
    input  memBusPkg::accessLen_t    i_dcLen,
    input  memBusPkg::addr_t         i_dcAddr,
    input  memBusPkg::word_t         i_dcData,

    input  logic                     i_engDone,
    input  memBusPkg::word_t         i_engResult,

    output logic                     o_start,
    output memCtrlPkg::accessKind_t  o_kind,
    output memBusPkg::addr_t         o_addr,
    output memBusPkg::accessLen_t    o_len,
    output memBusPkg::word_t         o_storeData,

    output logic                     o_fetchDone,
    output memBusPkg::word_t         o_fetchInst,
    output logic                     o_dcDone,
    output memBusPkg::word_t         o_dcData
);
    import memBusPkg::*;
    import memCtrlPkg::*;

    localparam accessLen_t FETCH_LEN = accessLen_t'(FETCH_BYTES);

    owner_t      owner;
    logic        startQ;
    accessKind_t kindQ;
    addr_t       addrQ;
    accessLen_t  lenQ;
    word_t       storeQ;

    // data port wins when both ask in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            owner  <= ownerIdle;
            startQ <= 1'b0;
        end else if (i_rdy) begin
            startQ <= 1'b0;
            case (owner)
                ownerIdle: begin
                    if (i_dcEn) begin
                        owner  <= ownerData;
                        startQ <= 1'b1;
                    end else if (i_fetchEn) begin
                        owner  <= ownerFetch;
                        startQ <= 1'b1;
                    end
                end
                default: begin
                    if (i_engDone) begin
                        owner <= ownerIdle;
                    end
                end
            endcase
        end
    end

    // request fields stay latched until the access ends
    always_ff @(posedge clk) begin
        if (i_rdy && owner == ownerIdle) begin
            if (i_dcEn) begin
                kindQ  <= i_dcStore ? kindWrite : kindRead;
                addrQ  <= i_dcAddr;
                lenQ   <= i_dcLen;
                storeQ <= i_dcData;
            end else if (i_fetchEn) begin
                kindQ <= kindRead;
                addrQ <= i_fetchAddr;
                lenQ  <= FETCH_LEN;
            end
        end
    end

    assign o_start     = startQ;
    assign o_kind      = kindQ;
    assign o_addr      = addrQ;
    assign o_len       = lenQ;
    assign o_storeData = storeQ;

    // only the owner sees the done pulse
    assign o_fetchDone = i_engDone && (owner == ownerFetch);
    assign o_dcDone    = i_engDone && (owner == ownerData);
    assign o_fetchInst = (owner == ownerFetch) ? i_engResult : '0;
    assign o_dcData    = (owner == ownerData) ? i_engResult : '0;

endmodule

/* verilog/memBusPkg.sv */
package memBusPkg;

    // processor side
    parameter int ADDR_W = 32;
    parameter int WORD_W = 32;

    // ram side
    parameter int BYTE_W = 8;

    // byte count of one access, 1, 2 or 4
    parameter int LEN_W = 3;

    // byte address into the shared ram
    typedef logic [ADDR_W-1:0] addr_t;

    // instruction or data word, little endian
    typedef logic [WORD_W-1:0] word_t;

    typedef logic [BYTE_W-1:0] memByte_t;

    typedef logic [LEN_W-1:0] accessLen_t;

endpackage

/* verilog/memCtrlPkg.sv */
package memCtrlPkg;

    // who currently owns the ram
    typedef enum logic [1:0] {
        ownerIdle,
        ownerFetch,
        ownerData
    } owner_t;

    typedef enum logic {
        kindRead,
        kindWrite
    } accessKind_t;

    parameter int STAGE_W = 3;

    // engine stage, 0 is idle, 1..n drive addresses
    // a read needs one more stage for the last byte
    typedef logic [STAGE_W-1:0] byteStage_t;

endpackage

/* verilog/memCtrlTop.sv */
`timescale 1ns/100ps

module memCtrlTop #(
    parameter int FETCH_BYTES = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_rdy,

    input  logic                   i_fetchEn,
    input  memBusPkg::addr_t       i_fetchAddr,
    output logic                   o_fetchDone,
    output memBusPkg::word_t       o_fetchInst,

    input  logic                   i_dcEn,
    input  logic                   i_dcStore,
    input  memBusPkg::accessLen_t  i_dcLen,
    input  memBusPkg::addr_t       i_dcAddr,
    input  memBusPkg::word_t       i_dcData,
    output logic                   o_dcDone,
    output memBusPkg::word_t       o_dcData,

    input  memBusPkg::memByte_t    i_memData,
    output memBusPkg::addr_t       o_memAddr,
    output logic                   o_memWrite,
    output memBusPkg::memByte_t    o_memData
);
    import memBusPkg::*;
    import memCtrlPkg::*;

    // arbiter to engine
    logic        start;
    accessKind_t kind;
    addr_t       addr;
    accessLen_t  len;
    word_t       storeData;
    logic        engDone;
    word_t       engResult;

    memArbiter #(
        .FETCH_BYTES (FETCH_BYTES)
    ) u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (i_rdy),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_dcEn      (i_dcEn),
        .i_dcStore   (i_dcStore),
        .i_dcLen     (i_dcLen),
        .i_dcAddr    (i_dcAddr),
        .i_dcData    (i_dcData),
        .i_engDone   (engDone),
        .i_engResult (engResult),
        .o_start     (start),
        .o_kind      (kind),
        .o_addr      (addr),
        .o_len       (len),
        .o_storeData (storeData),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dcDone    (o_dcDone),
        .o_dcData    (o_dcData)
    );

    byteEngine u_engine (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (i_rdy),
        .i_start     (start),
        .i_kind      (kind),
        .i_addr      (addr),
        .i_len       (len),
        .i_storeData (storeData),
        .i_memData   (i_memData),
        .o_memAddr   (o_memAddr),
        .o_memWrite  (o_memWrite),
        .o_memData   (o_memData),
        .o_done      (engDone),
        .o_result    (engResult)
    );

endmodule
